//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fpu_tb
FILELIST  ?= fpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fpu.f
fpu_pkg.sv
fpu_operand_unpack.sv
fpu_add_sub.sv
fpu_mul.sv
fpu_sequencer.sv
fpu_top.sv
fpu_tb.sv

//--- fpu_add_sub.sv
/*
  Combinational add/subtract datapath. Aligns the mantissas, adds them in
  two's complement and renormalizes with a leading-zero shift.
*/
`timescale 1ns/100ps

module fpu_add_sub (
  input  logic                subtract,
  input  logic                a_sign,
  input  fpu_pkg::exp_t       a_exp,
  input  fpu_pkg::mant_t      a_mant,
  input  logic                b_sign,
  input  fpu_pkg::exp_t       b_exp,
  input  fpu_pkg::mant_t      b_mant,
  output logic                sum_sign,
  output fpu_pkg::exp_t       sum_exp,
  output fpu_pkg::mant_t      sum_mant
);

  fpu_pkg::exp_t      big_exp;
  fpu_pkg::mant_ext_t a_align;
  fpu_pkg::mant_ext_t b_align;
  fpu_pkg::mant_ext_t a_twos;
  fpu_pkg::mant_ext_t b_twos;
  fpu_pkg::mant_ext_t sum_raw;
  fpu_pkg::mant_ext_t sum_mag;
  fpu_pkg::mant_ext_t sum_shl;
  logic [4:0]         norm_shift;

  // smaller operand moves right, shifted-out bits are lost
  assign big_exp = (a_exp < b_exp) ? b_exp : a_exp;
  assign a_align = (a_exp < b_exp) ? {2'b00, a_mant} >> (b_exp - a_exp) : {2'b00, a_mant};
  assign b_align = (b_exp < a_exp) ? {2'b00, b_mant} >> (a_exp - b_exp) : {2'b00, b_mant};

  // signed mantissas
  assign a_twos = a_sign ? -a_align : a_align;
  assign b_twos = b_sign ? -b_align : b_align;

  assign sum_raw = subtract ? a_twos - b_twos : a_twos + b_twos;

  // sign from bit 25, then back to magnitude
  assign sum_sign = sum_raw[25];
  assign sum_mag  = sum_raw[25] ? -sum_raw : sum_raw;

  // two guard bits sit above the 24-bit mantissa, so skip them in the count
  assign norm_shift = fpu_pkg::lzc(sum_mag) - 5'd2;
  assign sum_shl    = sum_mag << norm_shift;

  always_comb begin
    if (sum_mag == '0) begin
      // exact cancellation gives +0
      sum_exp  = '0;
      sum_mant = '0;
    end else if (sum_mag[24]) begin
      // carry out of bit 23
      sum_exp  = big_exp + 8'd1;
      sum_mant = sum_mag[24:1];
    end else begin
      sum_exp  = big_exp - fpu_pkg::exp_t'(norm_shift);
      sum_mant = sum_shl[23:0];
    end
  end

  // any nonzero result leaves with the hidden bit in place
  always_comb begin
    assert final (sum_mant == '0 || sum_mant[23])
      else $error("add/sub result not normalized: %h", sum_mant);
  end

endmodule

//--- fpu_mul.sv
/*
  Combinational multiply datapath. Forms the 48-bit mantissa product,
  normalizes, rounds to nearest even and renormalizes on rounding carry.
*/
`timescale 1ns/100ps

module fpu_mul (
  input  logic                a_sign,
  input  fpu_pkg::exp_t       a_exp,
  input  fpu_pkg::mant_t      a_mant,
  input  logic                b_sign,
  input  fpu_pkg::exp_t       b_exp,
  input  fpu_pkg::mant_t      b_mant,
  output logic                prod_sign,
  output fpu_pkg::exp_t       prod_exp,
  output fpu_pkg::mant_t      prod_mant
);

  logic [47:0] product;
  logic [47:0] product_norm;
  logic [9:0]  exp_sum;
  logic [9:0]  exp_norm;
  logic        round_bit;
  logic        sticky;
  logic        round_up;
  logic [24:0] rounded;

  assign prod_sign = a_sign ^ b_sign;

  // 1.x times 1.x lands in [1, 4)
  assign product = a_mant * b_mant;

  // widened so the bias subtraction cannot wrap early
  assign exp_sum = {2'b00, a_exp} + {2'b00, b_exp} - 10'(fpu_pkg::exp_bias);

  // top bit set means the product was 1x.xxx, bump the exponent
  // otherwise move the leading one up to bit 47
  assign exp_norm     = product[47] ? exp_sum + 10'd1 : exp_sum;
  assign product_norm = product[47] ? product : product << 1;

  // round to nearest, ties to even
  // bit 23 is the half bit, bits below it are the sticky part
  assign round_bit = product_norm[23];
  assign sticky    = |product_norm[22:0];
  assign round_up  = round_bit & (sticky | product_norm[24]);

  assign rounded = {1'b0, product_norm[47:24]} + 25'(round_up);

  always_comb begin
    if (rounded[24]) begin
      // all ones rounded up, result is 10.000
      prod_mant = rounded[24:1];
      prod_exp  = fpu_pkg::exp_t'(exp_norm + 10'd1);
    end else begin
      prod_mant = rounded[23:0];
      prod_exp  = fpu_pkg::exp_t'(exp_norm);
    end
  end

  // with two normal inputs the output is always normalized
  always_comb begin
    assert final (a_mant == '0 || b_mant == '0 || prod_mant[23])
      else $error("multiply result not normalized: %h", prod_mant);
  end

endmodule

//--- fpu_operand_unpack.sv
/*
  Operand decode stage. Splits both packed operands into sign, biased
  exponent and mantissa with hidden bit, registered on the load pulse.
*/
`timescale 1ns/100ps

module fpu_operand_unpack (
  input  logic                clk,
  input  logic                arst,
  input  logic                load,
  input  fpu_pkg::word_t      a_operand,
  input  fpu_pkg::word_t      b_operand,
  output logic                a_sign,
  output fpu_pkg::exp_t       a_exp,
  output fpu_pkg::mant_t      a_mant,
  output logic                b_sign,
  output fpu_pkg::exp_t       b_exp,
  output fpu_pkg::mant_t      b_mant
);

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      a_sign <= 1'b0;
      a_exp  <= '0;
      a_mant <= '0;
      b_sign <= 1'b0;
      b_exp  <= '0;
      b_mant <= '0;
    end else if (load) begin
      a_sign <= a_operand[31];
      a_exp  <= a_operand[30:fpu_pkg::frac_w];
      // hidden bit only for a nonzero exponent, zero stays all zero
      a_mant <= {a_operand[30:fpu_pkg::frac_w] != '0, a_operand[fpu_pkg::frac_w-1:0]};
      b_sign <= b_operand[31];
      b_exp  <= b_operand[30:fpu_pkg::frac_w];
      b_mant <= {b_operand[30:fpu_pkg::frac_w] != '0, b_operand[fpu_pkg::frac_w-1:0]};
    end
  end

endmodule

//--- fpu_pkg.sv
/*
  Shared types, constants and helpers for the single-precision FPU.
  Modules refer to these by scoped names.
*/
package fpu_pkg;

  // field widths and bias of an IEEE-754 single
  localparam int unsigned frac_w   = 23;
  localparam int unsigned exp_bias = 127;

  // full packed word, used for operands and result
  typedef logic [31:0] word_t;

  // biased exponent
  typedef logic [7:0] exp_t;

  // mantissa with hidden bit at bit 23
  typedef logic [23:0] mant_t;

  // signed add/sub mantissa
  // bit 25 is the sign, bit 24 catches the carry out of bit 23
  typedef logic [25:0] mant_ext_t;

  // command opcodes
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_e;

  // command sequencer states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_load    = 2'd1,
    st_execute = 2'd2,
    st_done    = 2'd3
  } seq_state_e;

  // leading zero count of a 26-bit value, 26 when all zero
  function automatic logic [4:0] lzc(input mant_ext_t value);
    logic [4:0] count;
    count = 5'd26;
    // scan upward so the highest set bit is the one that sticks
    for (int i = 0; i < 26; i++) begin
      if (value[i]) begin
        count = 5'(25 - i);
      end
    end
    return count;
  endfunction

endpackage

//--- fpu_sequencer.sv
/*
  Command sequencer for the FPU. Runs the start/busy/cmd_end handshake,
  pulses the operand load, captures the opcode and owns the result register.
*/
`timescale 1ns/100ps

module fpu_sequencer (
  input  logic                clk,
  input  logic                arst,
  input  logic                start,
  input  fpu_pkg::fpu_op_e    operation,
  input  logic                sum_sign,
  input  fpu_pkg::exp_t       sum_exp,
  input  fpu_pkg::mant_t      sum_mant,
  input  logic                prod_sign,
  input  fpu_pkg::exp_t       prod_exp,
  input  fpu_pkg::mant_t      prod_mant,
  output logic                load,
  output logic                subtract,
  output fpu_pkg::word_t      result,
  output logic                busy,
  output logic                cmd_end
);

  fpu_pkg::seq_state_e state;
  fpu_pkg::fpu_op_e    op_q;
  fpu_pkg::word_t      packed_res;

  // repack without the hidden bit, picked by the captured opcode
  assign packed_res = (op_q == fpu_pkg::op_mul) ?
                      {prod_sign, prod_exp, prod_mant[fpu_pkg::frac_w-1:0]} :
                      {sum_sign, sum_exp, sum_mant[fpu_pkg::frac_w-1:0]};

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= fpu_pkg::st_idle;
      op_q     <= fpu_pkg::op_add;
      load     <= 1'b0;
      subtract <= 1'b0;
      result   <= '0;
      busy     <= 1'b0;
      cmd_end  <= 1'b0;
    end else begin
      // load lives for one cycle only
      load <= 1'b0;
      case (state)
        fpu_pkg::st_idle: begin
          if (start) begin
            state    <= fpu_pkg::st_load;
            op_q     <= operation;
            subtract <= (operation == fpu_pkg::op_sub);
            load     <= 1'b1;
            busy     <= 1'b1;
          end
        end
        // operands are registered at the end of this cycle
        fpu_pkg::st_load: state <= fpu_pkg::st_execute;
        fpu_pkg::st_execute: begin
          result <= packed_res;
          state  <= fpu_pkg::st_done;
        end
        fpu_pkg::st_done: begin
          // hold result and cmd_end until the host lets go of start
          if (start) begin
            cmd_end <= 1'b1;
          end else begin
            state   <= fpu_pkg::st_idle;
            busy    <= 1'b0;
            cmd_end <= 1'b0;
          end
        end
        default: state <= fpu_pkg::st_idle;
      endcase
    end
  end

  // end of command only ever shows up inside a busy window
  assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("cmd_end high while not busy");

  // a command must carry a known opcode when it is accepted
  assert property (@(posedge clk) disable iff (arst)
    (state == fpu_pkg::st_idle && start) |->
      (operation inside {fpu_pkg::op_add, fpu_pkg::op_sub, fpu_pkg::op_mul}))
    else $error("undefined opcode at command start");

endmodule

//--- fpu_tb.sv
/*
  Self-checking testbench for the FPU. Runs add, sub and mul commands
  through the start/busy/cmd_end handshake while concurrent assertions check.
*/
`timescale 1ns/100ps

module fpu_tb;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 5;
  localparam int num_random   = 40;
  // three random batches plus the directed commands
  localparam int num_cmds     = 3 * num_random + 13;

  logic             clk;
  logic             arst;
  fpu_pkg::word_t   a_operand;
  fpu_pkg::word_t   b_operand;
  fpu_pkg::fpu_op_e operation;
  logic             start;
  fpu_pkg::word_t   result;
  logic             busy;
  logic             cmd_end;

  fpu_pkg::word_t   expected;
  bit               cmd_seen;
  int               errors;
  int               cmds_done;

  fpu_top dut (
    .clk, .arst, .a_operand, .b_operand, .operation, .start,
    .result, .busy, .cmd_end
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // add/sub model with truncating alignment
  function automatic fpu_pkg::word_t addsub_ref(fpu_pkg::word_t a, fpu_pkg::word_t b, bit sub);
    longint ma;
    longint mb;
    longint sum;
    int     ea;
    int     eb;
    int     e;
    bit     s;
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    ma = (ea != 0) ? longint'({1'b1, a[22:0]}) : 64'sd0;
    mb = (eb != 0) ? longint'({1'b1, b[22:0]}) : 64'sd0;
    e  = (ea > eb) ? ea : eb;
    if (ea > eb) mb = mb >> (ea - eb);
    if (eb > ea) ma = ma >> (eb - ea);
    if (a[31]) ma = -ma;
    if (b[31]) mb = -mb;
    sum = sub ? ma - mb : ma + mb;
    s   = (sum < 0);
    if (s) sum = -sum;
    // exact cancellation is +0
    if (sum == 0) return '0;
    if (sum >= 64'sh1000000) begin
      sum = sum >> 1;
      e++;
    end
    // walk the leading one back up to bit 23
    while (sum < 64'sh800000) begin
      sum = sum << 1;
      e--;
    end
    return {s, 8'(e), 23'(sum)};
  endfunction

  // multiply model with round to nearest even
  function automatic fpu_pkg::word_t mul_ref(fpu_pkg::word_t a, fpu_pkg::word_t b);
    logic [47:0] p;
    logic [24:0] top;
    logic [23:0] rest;
    int          e;
    p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - 127;
    if (p[47]) e++;
    else p = p << 1;
    top  = {1'b0, p[47:24]};
    rest = p[23:0];
    // above half goes up and exactly half goes to the even neighbor
    if (rest > 24'h800000 || (rest == 24'h800000 && top[0])) top = top + 25'd1;
    if (top[24]) begin
      top = top >> 1;
      e++;
    end
    return {a[31] ^ b[31], 8'(e), top[22:0]};
  endfunction

  function automatic fpu_pkg::word_t expected_result(fpu_pkg::word_t a, fpu_pkg::word_t b,
                                                     fpu_pkg::fpu_op_e op);
    if (op == fpu_pkg::op_mul) return mul_ref(a, b);
    return addsub_ref(a, b, op == fpu_pkg::op_sub);
  endfunction

  // exponent kept in 100..154 so nothing over- or underflows
  function automatic fpu_pkg::word_t random_operand();
    logic [7:0] e;
    e = 8'($urandom_range(154, 100));
    return {1'($urandom_range(1, 0)), e, 23'($urandom)};
  endfunction

  // one full handshake with start held for hold extra cycles after cmd_end
  task automatic run_command(input fpu_pkg::word_t a, input fpu_pkg::word_t b,
                             input fpu_pkg::fpu_op_e op, input int hold);
    int wait_cycles;
    @(negedge clk);
    a_operand = a;
    b_operand = b;
    operation = op;
    expected  = expected_result(a, b, op);
    start     = 1'b1;
    cmd_seen  = 1'b1;
    wait_cycles = 0;
    while (!cmd_end && wait_cycles < 8) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!cmd_end) begin
      errors++;
      $display("cmd_end did not rise within 8 cycles of start");
    end
    // operands wander while the result is held
    repeat (hold) begin
      @(negedge clk);
      a_operand = $urandom;
      b_operand = $urandom;
    end
    start = 1'b0;
    wait_cycles = 0;
    while (busy && wait_cycles < 4) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (busy) begin
      errors++;
      $display("busy stayed high after start was released");
    end
    cmds_done++;
  endtask

  // quiet outputs until the first command
  assert property (@(posedge clk) disable iff (arst) !cmd_seen |-> (!busy && !cmd_end))
    else begin
      errors++;
      $display("busy or cmd_end high before any command");
    end
  assert property (@(posedge clk) disable iff (arst) !cmd_seen |-> (result == '0))
    else begin
      errors++;
      $display("Fail result expected 00000000 got %h", result);
    end

  // busy follows start at once and cmd_end comes exactly 3 edges later
  assert property (@(posedge clk) disable iff (arst) (start && !busy) |=> busy)
    else begin
      errors++;
      $display("busy did not rise at the edge that sampled start");
    end
  assert property (@(posedge clk) disable iff (arst)
    $rose(cmd_end) |-> ($past(busy, 3) && !$past(busy, 4)))
    else begin
      errors++;
      $display("cmd_end rose at the wrong distance from start");
    end
  assert property (@(posedge clk) disable iff (arst)
    ($past(busy, 3) && !$past(busy, 4) && $past(start)) |-> cmd_end)
    else begin
      errors++;
      $display("cmd_end missing 3 edges after start");
    end

  // back-pressure holds everything steady and release drops both flags
  assert property (@(posedge clk) disable iff (arst)
    (cmd_end && start) |=> (cmd_end && busy && $stable(result)))
    else begin
      errors++;
      $display("result or flags moved while start was held");
    end
  assert property (@(posedge clk) disable iff (arst) (cmd_end && !start) |=> (!busy && !cmd_end))
    else begin
      errors++;
      $display("busy or cmd_end did not drop when start was released");
    end

  assert property (@(posedge clk) disable iff (arst) cmd_end |-> (result == expected))
    else begin
      errors++;
      $display("Fail result expected %h got %h", expected, result);
    end

  initial begin
    #((num_cmds * 12 + reset_cycles + 8) * clk_period);
    $display("watchdog expired after %0d commands, the DUT stopped answering", cmds_done);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    fpu_pkg::word_t op_a;
    fpu_pkg::word_t op_b;
    void'($urandom(24134));
    errors    = 0;
    cmds_done = 0;
    cmd_seen  = 1'b0;
    arst      = 1'b1;
    start     = 1'b0;
    a_operand = '0;
    b_operand = '0;
    operation = fpu_pkg::op_add;
    expected  = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst = 1'b0;
    repeat (3) @(negedge clk);

    // adds with a zero operand and an exact cancellation
    run_command(32'h3f800000, 32'h40000000, fpu_pkg::op_add, 0);
    run_command(32'h00000000, 32'hc1200000, fpu_pkg::op_add, 1);
    run_command(32'h42f60000, 32'h00000000, fpu_pkg::op_add, 0);
    run_command(32'h40490fdb, 32'hc0490fdb, fpu_pkg::op_add, 2);
    // subtracts that need a long left shift or have mixed signs
    run_command(32'h3f800000, 32'h3f7fffff, fpu_pkg::op_sub, 0);
    run_command(32'hc2c80001, 32'hc2c80000, fpu_pkg::op_sub, 1);
    run_command(32'h41200000, 32'hc0a00000, fpu_pkg::op_sub, 0);
    // ties up and down and a tie whose round up carries out
    run_command(32'h3f800001, 32'h3fc00000, fpu_pkg::op_mul, 0);
    run_command(32'h3f800003, 32'h3fc00000, fpu_pkg::op_mul, 0);
    run_command(32'h3f842108, 32'h3ff80000, fpu_pkg::op_mul, 1);
    run_command(32'hbf842108, 32'h3ff80000, fpu_pkg::op_mul, 0);
    run_command(32'h3fffffff, 32'h3fffffff, fpu_pkg::op_mul, 0);
    run_command(32'h3f7fffff, 32'hbf800001, fpu_pkg::op_mul, 2);

    for (int i = 0; i < num_random; i++) begin
      op_a = random_operand();
      op_b = random_operand();
      run_command(op_a, op_b, fpu_pkg::op_add, int'($urandom_range(3, 0)));
    end
    for (int i = 0; i < num_random; i++) begin
      op_a = random_operand();
      op_b = random_operand();
      // every other one only differs in low fraction bits
      if (i % 2 == 1) op_b = op_a ^ (32'h00000fff & $urandom);
      run_command(op_a, op_b, fpu_pkg::op_sub, int'($urandom_range(3, 0)));
    end
    for (int i = 0; i < num_random; i++) begin
      op_a = random_operand();
      op_b = random_operand();
      run_command(op_a, op_b, fpu_pkg::op_mul, int'($urandom_range(3, 0)));
    end

    repeat (2) @(negedge clk);
    $display("commands %0d, errors %0d", cmds_done, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- fpu_top.sv
/*
  Top level of the multicycle FPU. Ties operand decode, the add/sub and
  multiply datapaths and the command sequencer together.
*/
`timescale 1ns/100ps

module fpu_top (
  input  logic                clk,
  input  logic                arst,
  input  fpu_pkg::word_t      a_operand,
  input  fpu_pkg::word_t      b_operand,
  input  fpu_pkg::fpu_op_e    operation,
  input  logic                start,
  output fpu_pkg::word_t      result,
  output logic                busy,
  output logic                cmd_end
);

  // sequencer controls
  logic           load;
  logic           subtract;

  // unpacked operand fields
  logic           a_sign;
  fpu_pkg::exp_t  a_exp;
  fpu_pkg::mant_t a_mant;
  logic           b_sign;
  fpu_pkg::exp_t  b_exp;
  fpu_pkg::mant_t b_mant;

  // datapath results
  logic           sum_sign;
  fpu_pkg::exp_t  sum_exp;
  fpu_pkg::mant_t sum_mant;
  logic           prod_sign;
  fpu_pkg::exp_t  prod_exp;
  fpu_pkg::mant_t prod_mant;

  fpu_operand_unpack u_unpack (
    .clk, .arst, .load, .a_operand, .b_operand,
    .a_sign, .a_exp, .a_mant, .b_sign, .b_exp, .b_mant
  );

  fpu_add_sub u_add_sub (
    .subtract, .a_sign, .a_exp, .a_mant, .b_sign, .b_exp, .b_mant,
    .sum_sign, .sum_exp, .sum_mant
  );

  fpu_mul u_mul (
    .a_sign, .a_exp, .a_mant, .b_sign, .b_exp, .b_mant,
    .prod_sign, .prod_exp, .prod_mant
  );

  fpu_sequencer u_sequencer (
    .clk, .arst, .start, .operation,
    .sum_sign, .sum_exp, .sum_mant, .prod_sign, .prod_exp, .prod_mant,
    .load, .subtract, .result, .busy, .cmd_end
  );

endmodule
